// File: verilog/tri_pkg.sv
package tri_pkg;

    typedef logic signed [15:0] coord_t;
    typedef logic [11:0] depth_t;     // 11-bit depth zero-extended to 12
    typedef logic [15:0] color_t;     // rgb565
    typedef logic [2:0] kind_t;
    typedef logic [1:0] lane_t;
    typedef logic [4:0] vert_idx_t;

    typedef struct packed {
        kind_t       kind;
        lane_t       lane;
        logic [10:0] depth;
    } obstacle_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef enum logic {x_left, x_right} x_sel_e;
    typedef enum logic [2:0] {y_ground, y_mid, y_top, y_mid_lo, y_mid_hi} y_sel_e;
    typedef enum logic [1:0] {z_barrier, z_car_front, z_depth} z_sel_e;

    // one table entry that the former resolves to coordinates
    typedef struct packed {
        x_sel_e x_sel;
        y_sel_e y_sel;
        z_sel_e z_sel;
        color_t color;
        logic   last;
    } corner_t;

    typedef enum logic {seq_idle, seq_emit} seq_state_e;

    // lane edges with x growing to the right
    localparam coord_t left_lane_l  = -16'sd128;
    localparam coord_t left_lane_r  = -16'sd64;
    localparam coord_t mid_lane_l   = -16'sd32;
    localparam coord_t mid_lane_r   = 16'sd32;
    localparam coord_t right_lane_l = 16'sd64;
    localparam coord_t right_lane_r = 16'sd128;

    // screen y grows downwards
    localparam coord_t height_ground = 16'sd128;
    localparam coord_t height_mid    = 16'sd96;
    localparam coord_t height_top    = 16'sd64;
    localparam coord_t mid_band      = 16'sd8;  // half height of the middle barrier

    localparam coord_t barrier_len = 16'sd32;
    localparam coord_t car_len     = 16'sd128;

    localparam kind_t kind_low  = 3'd1;
    localparam kind_t kind_high = 3'd2;
    localparam kind_t kind_mid  = 3'd3;
    localparam kind_t kind_car  = 3'd4;

    localparam color_t color_low       = 16'hF000;  // red
    localparam color_t color_high      = 16'hFE18;  // pink
    localparam color_t color_middle    = 16'hFD00;  // orange
    localparam color_t color_car_front = 16'h001F;
    localparam color_t color_car_left  = 16'h000F;
    localparam color_t color_car_right = 16'h000A;
    localparam color_t color_car_roof  = 16'h312F;

endpackage

// File: verilog/obstacle_decoder.sv
module obstacle_decoder import tri_pkg::*; #(
    parameter coord_t min_z = 16'sd8
) (
    input  logic      clk,
    input  logic      rst,
    input  obstacle_t obstacle,
    input  logic      obstacle_valid,
    input  logic      busy,
    output logic      start,
    output kind_t     kind,
    output coord_t    lane_left,
    output coord_t    lane_right,
    output depth_t    depth
);

    logic   accept;
    logic   is_barrier;
    logic   too_near;
    depth_t in_depth;

    // start counts as busy too since the sequencer raises busy a cycle later
    assign accept = obstacle_valid && !busy && !start;

    assign in_depth   = {1'b0, obstacle.depth};
    assign is_barrier = obstacle.kind inside {kind_low, kind_high, kind_mid};
    assign too_near   = coord_t'({4'b0000, in_depth}) < (barrier_len + min_z);

    always_ff @(posedge clk) begin
        if (accept) begin
            kind  <= obstacle.kind;
            depth <= in_depth;
            case (obstacle.lane)
                2'd0: begin
                    lane_left  <= left_lane_l;
                    lane_right <= left_lane_r;
                end
                2'd1: begin
                    lane_left  <= mid_lane_l;
                    lane_right <= mid_lane_r;
                end
                default: begin  // lanes 2 and 3 both map right
                    lane_left  <= right_lane_l;
                    lane_right <= right_lane_r;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= accept && (is_barrier ? !too_near : (obstacle.kind == kind_car));
        end
    end

endmodule

// File: verilog/corner_table.sv
module corner_table import tri_pkg::*; (
    input  kind_t     kind,
    input  vert_idx_t index,
    output corner_t   corner
);

    y_sel_e y_lo;
    y_sel_e y_hi;
    color_t bar_color;

    function automatic corner_t place(input x_sel_e x, input y_sel_e y, input z_sel_e z);
        corner_t c;
        c       = '0;
        c.x_sel = x;
        c.y_sel = y;
        c.z_sel = z;
        return c;
    endfunction

    always_comb begin
        // barrier band and colour
        y_lo      = y_ground;
        y_hi      = y_mid;
        bar_color = color_low;
        case (kind)
            kind_high: begin
                y_lo      = y_mid;
                y_hi      = y_top;
                bar_color = color_high;
            end
            kind_mid: begin
                y_lo      = y_mid_lo;
                y_hi      = y_mid_hi;
                bar_color = color_middle;
            end
            default: ;
        endcase

        corner      = place(x_left, y_ground, z_depth);
        corner.last = 1'b1;  // nothing to draw

        if (kind inside {kind_low, kind_high, kind_mid}) begin
            // two triangles facing the camera
            case (index)
                5'd0: corner = place(x_left, y_lo, z_barrier);
                5'd1: corner = place(x_right, y_lo, z_barrier);
                5'd2: corner = place(x_left, y_hi, z_barrier);
                5'd3: corner = place(x_right, y_lo, z_barrier);
                5'd4: corner = place(x_right, y_hi, z_barrier);
                default: corner = place(x_left, y_hi, z_barrier);
            endcase
            corner.color = bar_color;
            corner.last  = (index == 5'd5);
        end else if (kind == kind_car) begin
            case (index)
                // front face
                5'd0:  corner = place(x_left, y_ground, z_car_front);
                5'd1:  corner = place(x_right, y_ground, z_car_front);
                5'd2:  corner = place(x_left, y_top, z_car_front);
                5'd3:  corner = place(x_right, y_ground, z_car_front);
                5'd4:  corner = place(x_right, y_top, z_car_front);
                5'd5:  corner = place(x_left, y_top, z_car_front);
                // left side
                5'd6:  corner = place(x_left, y_ground, z_car_front);
                5'd7:  corner = place(x_left, y_top, z_car_front);
                5'd8:  corner = place(x_left, y_ground, z_depth);
                5'd9:  corner = place(x_left, y_top, z_car_front);
                5'd10: corner = place(x_left, y_top, z_depth);
                5'd11: corner = place(x_left, y_ground, z_depth);
                // right side
                5'd12: corner = place(x_right, y_top, z_car_front);
                5'd13: corner = place(x_right, y_top, z_depth);
                5'd14: corner = place(x_right, y_ground, z_car_front);
                5'd15: corner = place(x_right, y_ground, z_car_front);
                5'd16: corner = place(x_right, y_top, z_depth);
                5'd17: corner = place(x_right, y_ground, z_depth);
                // roof
                5'd18: corner = place(x_left, y_top, z_car_front);
                5'd19: corner = place(x_right, y_top, z_car_front);
                5'd20: corner = place(x_right, y_top, z_depth);
                5'd21: corner = place(x_right, y_top, z_depth);
                5'd22: corner = place(x_left, y_top, z_depth);
                default: corner = place(x_left, y_top, z_car_front);
            endcase

            if (index < 5'd6) begin
                corner.color = color_car_front;
            end else if (index < 5'd12) begin
                corner.color = color_car_left;
            end else if (index < 5'd18) begin
                corner.color = color_car_right;
            end else begin
                corner.color = color_car_roof;
            end
            corner.last = (index == 5'd23);
        end
    end

endmodule

// File: verilog/vertex_sequencer.sv
module vertex_sequencer import tri_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  kind_t   kind,
    output logic    busy,
    output corner_t corner,
    output logic    corner_valid,
    output logic    first
);

    seq_state_e state;
    vert_idx_t  index;
    logic [1:0] phase;  // vertex position within its triangle

    corner_table u_table (
        .kind   (kind),
        .index  (index),
        .corner (corner)
    );

    assign busy = (state == seq_emit);

    // vertex 0 goes out in the start cycle itself
    assign corner_valid = start || busy;
    assign first        = corner_valid && (phase == 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle: begin
                    if (start && !corner.last) begin
                        state <= seq_emit;
                    end
                end
                seq_emit: begin
                    if (corner.last) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
            phase <= 2'd0;
        end else if (corner_valid) begin
            if (corner.last) begin
                index <= '0;
                phase <= 2'd0;
            end else begin
                index <= index + 5'd1;
                phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
            end
        end
    end

endmodule

// File: verilog/vertex_former.sv
module vertex_former import tri_pkg::*; #(
    parameter coord_t min_z = 16'sd8
) (
    input  logic    clk,
    input  logic    rst,
    input  corner_t corner,
    input  logic    corner_valid,
    input  logic    first,
    input  coord_t  lane_left,
    input  coord_t  lane_right,
    input  depth_t  depth,
    output vertex_t vertex,
    output color_t  color,
    output logic    new_triangle
);

    coord_t x_next;
    coord_t y_next;
    coord_t z_raw;
    coord_t depth_ext;

    assign depth_ext = coord_t'({4'b0000, depth});

    always_comb begin
        x_next = (corner.x_sel == x_left) ? lane_left : lane_right;
        case (corner.y_sel)
            y_mid:    y_next = height_mid;
            y_top:    y_next = height_top;
            y_mid_lo: y_next = height_mid - mid_band;
            y_mid_hi: y_next = height_mid + mid_band;
            default:  y_next = height_ground;
        endcase
        case (corner.z_sel)
            z_barrier:   z_raw = depth_ext - barrier_len;
            z_car_front: z_raw = depth_ext - car_len;  // may go negative near camera
            default:     z_raw = depth_ext;
        endcase
    end

    always_ff @(posedge clk) begin
        if (corner_valid) begin
            vertex.x <= x_next;
            vertex.y <= y_next;
            vertex.z <= (z_raw < min_z) ? min_z : z_raw;
            color    <= corner.color;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            new_triangle <= 1'b0;
        end else begin
            new_triangle <= corner_valid && first;
        end
    end

endmodule

// File: verilog/triangle_creator.sv
module triangle_creator import tri_pkg::*; #(
    parameter coord_t min_z = 16'sd8  // nearest z the renderer accepts
) (
    input  logic      clk,
    input  logic      rst,
    input  obstacle_t obstacle,
    input  logic      obstacle_valid,
    output vertex_t   vertex,
    output color_t    color,
    output logic      new_triangle
);

    logic    start;
    logic    busy;
    kind_t   kind;
    coord_t  lane_left;
    coord_t  lane_right;
    depth_t  depth;
    corner_t corner;
    logic    corner_valid;
    logic    first;

    obstacle_decoder #(.min_z(min_z)) u_decoder (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .busy           (busy),
        .start          (start),
        .kind           (kind),
        .lane_left      (lane_left),
        .lane_right     (lane_right),
        .depth          (depth)
    );

    vertex_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .kind         (kind),
        .busy         (busy),
        .corner       (corner),
        .corner_valid (corner_valid),
        .first        (first)
    );

    vertex_former #(.min_z(min_z)) u_former (
        .clk          (clk),
        .rst          (rst),
        .corner       (corner),
        .corner_valid (corner_valid),
        .first        (first),
        .lane_left    (lane_left),
        .lane_right   (lane_right),
        .depth        (depth),
        .vertex       (vertex),
        .color        (color),
        .new_triangle (new_triangle)
    );

endmodule

// File: dv/triangle_creator_chk.sv
module triangle_creator_chk import tri_pkg::*; #(
    parameter coord_t min_z = 16'sd8
) (
    input logic    clk,
    input logic    rst,
    input logic    new_triangle,
    input logic    corner_valid,
    input vertex_t vertex
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_quiet: assert property (@(posedge clk) rst |=> !new_triangle)
        else $error("new_triangle high after a reset edge");

    // a triangle takes three vertices
    a_spacing: assert property (@(posedge clk) disable iff (rst)
        new_triangle |=> !new_triangle ##1 !new_triangle)
        else $error("new_triangle pulses closer than three cycles");

    a_next_triangle: assert property (@(posedge clk) disable iff (rst)
        $past(new_triangle, 2) && corner_valid |=> new_triangle)
        else $error("next triangle of an obstacle not three cycles later");

    // vertex registers one edge after each valid corner
    a_z_floor: assert property (@(posedge clk) disable iff (rst)
        corner_valid |=> vertex.z >= min_z)
        else $error("vertex z below min_z");

endmodule

bind triangle_creator triangle_creator_chk #(.min_z(min_z)) u_chk (
    .clk          (clk),
    .rst          (rst),
    .new_triangle (new_triangle),
    .corner_valid (corner_valid),
    .vertex       (vertex)
);

// File: dv/triangle_ref.svh
`ifndef TRIANGLE_REF_SVH
`define TRIANGLE_REF_SVH

localparam int nearest_z = 8;

function automatic int vertex_count(input obstacle_t ob);
    if (ob.kind inside {3'd1, 3'd2, 3'd3}) begin
        return (int'(ob.depth) < 32 + nearest_z) ? 0 : 6;  // culled when too near
    end
    return (ob.kind == 3'd4) ? 24 : 0;
endfunction

function automatic int lane_edge(input lane_t lane, input logic right_side);
    case (lane)
        2'd0:    return right_side ? -64 : -128;
        2'd1:    return right_side ? 32 : -32;
        default: return right_side ? 128 : 64;
    endcase
endfunction

function automatic int clamp_z(input int z);
    return (z < nearest_z) ? nearest_z : z;
endfunction

// masks pick right edge, upper height and far z per vertex of a face
function automatic vertex_t predict_vertex(input obstacle_t ob, input int k);
    vertex_t    v;
    logic [2:0] j;
    logic [5:0] right_m;
    logic [5:0] top_m;
    logic [5:0] far_m;
    int         lo_y;
    int         hi_y;
    int         near_z;
    int         far_z;
    j     = 3'(k % 6);
    far_z = int'(ob.depth);
    if (ob.kind == 3'd4) begin
        near_z = far_z - 128;
        lo_y   = 128;
        hi_y   = 64;
        case (k / 6)
            0:       {right_m, top_m, far_m} = {6'b011010, 6'b110100, 6'b000000};
            1:       {right_m, top_m, far_m} = {6'b000000, 6'b011010, 6'b110100};
            2:       {right_m, top_m, far_m} = {6'b111111, 6'b010011, 6'b110010};
            default: {right_m, top_m, far_m} = {6'b001110, 6'b111111, 6'b011100};
        endcase
    end else begin
        near_z  = far_z - 32;
        right_m = 6'b011010;  // same winding as the car front
        top_m   = 6'b110100;
        far_m   = 6'b000000;
        case (ob.kind)
            3'd1:    {lo_y, hi_y} = {32'd128, 32'd96};
            3'd2:    {lo_y, hi_y} = {32'd96, 32'd64};
            default: {lo_y, hi_y} = {32'd88, 32'd104};
        endcase
    end
    v.x = coord_t'(lane_edge(ob.lane, right_m[j]));
    v.y = coord_t'(top_m[j] ? hi_y : lo_y);
    v.z = coord_t'(clamp_z(far_m[j] ? far_z : near_z));
    return v;
endfunction

function automatic color_t shade_of(input obstacle_t ob, input int k);
    case (ob.kind)
        3'd1: return 16'hF000;
        3'd2: return 16'hFE18;
        3'd3: return 16'hFD00;
        default: begin
            case (k / 6)
                0:       return 16'h001F;  // front
                1:       return 16'h000F;
                2:       return 16'h000A;
                default: return 16'h312F;  // roof
            endcase
        end
    endcase
endfunction

`endif

// File: dv/triangle_creator_tb.sv
module triangle_creator_tb import tri_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        vertex_t     vertex;
        color_t      color;
        logic [31:0] due;  // rising-edge count when the vertex shows
    } expect_t;

    logic        clk;
    logic        rst;
    obstacle_t   obstacle;
    logic        obstacle_valid;
    vertex_t     vertex;
    color_t      color;
    logic        new_triangle;
    logic [31:0] cycle;
    expect_t     expect_q[$];

    `include "triangle_ref.svh"

    triangle_creator #(.min_z(16'sd8)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .vertex         (vertex),
        .color          (color),
        .new_triangle   (new_triangle)
    );

    initial begin
        clk   = 1'b0;
        cycle = '0;
        forever begin
            #50 clk = 1'b1;
            cycle = cycle + 32'd1;
            #50 clk = 1'b0;
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one-cycle valid that queues the vertices only if the DUT should draw them
    task automatic offer(input obstacle_t ob, input logic drawn);
        expect_t e;
        int      n;
        @(negedge clk);
        obstacle       = ob;
        obstacle_valid = 1'b1;
        n = drawn ? vertex_count(ob) : 0;
        for (int k = 0; k < n; k++) begin
            e.vertex = predict_vertex(ob, k);
            e.color  = shade_of(ob, k);
            e.due    = cycle + 32'(2 + k);
            expect_q.push_back(e);
        end
        @(negedge clk);
        obstacle_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
            guard++;
            if (guard > 60) stop_run("timeout: expected vertices never appeared");
        end
    endtask

    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            if (new_triangle === 1'b1) begin
                for (int i = 0; i < 3; i++) begin
                    if (i > 0) @(negedge clk);
                    assert (expect_q.size() > 0)
                        else stop_run($sformatf("vertex output at %0t with nothing pending", $time));
                    e = expect_q.pop_front();
                    assert (new_triangle === (i == 0))
                        else stop_run($sformatf("Fail at %0t: new_triangle wrong at vertex %0d",
                                                $time, i));
                    assert (cycle == e.due)
                        else stop_run($sformatf("Fail at %0t: vertex at cycle %0d, expected %0d",
                                                $time, cycle, e.due));
                    assert (vertex == e.vertex && color == e.color)
                        else stop_run($sformatf("Fail at %0t: got %h/%h, expected %h/%h", $time,
                                                vertex, color, e.vertex, e.color));
                end
            end
        end
    end

    initial begin : stimulus
        obstacle_t ob;
        void'($urandom(32'h9c2cf642));
        rst            = 1'b1;
        obstacle       = '0;
        obstacle_valid = 1'b0;
        repeat (16) begin
            @(negedge clk);
            assert (new_triangle !== 1'b1) else stop_run("new_triangle pulsed during reset");
        end
        rst = 1'b0;
        idle_cycles(5);

        // barriers in every lane
        for (int kind = 1; kind <= 3; kind++) begin
            for (int lane = 0; lane < 4; lane++) begin
                ob.kind  = kind_t'(kind);
                ob.lane  = lane_t'(lane);
                ob.depth = 11'(40 + $urandom_range(2007));
                offer(ob, 1'b1);
                wait_drained();
            end
        end
        ob = '{kind: 3'd1, lane: 2'd1, depth: 11'd40};  // nearest drawn depth
        offer(ob, 1'b1);
        wait_drained();

        // train car at random depths plus clamped fronts
        for (int lane = 0; lane < 4; lane++) begin
            ob.kind  = 3'd4;
            ob.lane  = lane_t'(lane);
            ob.depth = 11'($urandom_range(2047));
            offer(ob, 1'b1);
            wait_drained();
        end
        ob = '{kind: 3'd4, lane: 2'd3, depth: 11'd100};
        offer(ob, 1'b1);
        wait_drained();
        ob = '{kind: 3'd4, lane: 2'd0, depth: 11'd0};
        offer(ob, 1'b1);
        wait_drained();

        // culled barriers and empty kinds
        for (int kind = 0; kind < 8; kind++) begin
            ob.kind  = kind_t'(kind);
            ob.lane  = lane_t'($urandom_range(3));
            ob.depth = (kind >= 1 && kind <= 3) ? 11'($urandom_range(39))
                                                : 11'($urandom_range(2047));
            if (kind != 4) begin
                offer(ob, 1'b0);
                idle_cycles(30);
            end
        end

        // offer while the car is still emitting
        ob = '{kind: 3'd4, lane: 2'd1, depth: 11'd600};
        offer(ob, 1'b1);
        idle_cycles(1 + $urandom_range(17));
        offer(obstacle_t'{kind: 3'd2, lane: 2'd0, depth: 11'd500}, 1'b0);
        wait_drained();
        offer(obstacle_t'{kind: 3'd3, lane: 2'd2, depth: 11'd300}, 1'b1);
        wait_drained();

        idle_cycles(10);
        if (expect_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("vertices still pending at the end of the run");
            $display("FAIL: see errors above");
            $fatal(1, "simulation ended with pending vertices");
        end
    end

endmodule

// File: sim.f
verilog/tri_pkg.sv
verilog/obstacle_decoder.sv
verilog/corner_table.sv
verilog/vertex_sequencer.sv
verilog/vertex_former.sv
verilog/triangle_creator.sv
+incdir+dv
dv/triangle_creator_chk.sv
dv/triangle_creator_tb.sv

// File: run.sh
#!/bin/sh
# build and run the triangle_creator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module triangle_creator_tb -Mdir obj_dir -o triangle_creator_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/triangle_creator_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
